// File: csr_pkg.sv
// CSR addresses, operation, privilege and cause codes, write masks, shared structs
package csr_pkg;

    // Implemented CSR addresses
    typedef enum logic [11:0] {
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15,
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,     // User read-only aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Synchronous exception causes, mcause bit 31 clear
    typedef enum logic [4:0] {
        INSTR_MISALIGNED    = 5'd0,
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        LOAD_MISALIGNED     = 5'd4,
        STORE_MISALIGNED    = 5'd6,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    // Interrupt causes, also the mie/mip bit positions
    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    // Writable bits per register
    localparam logic [31:0] MSTATUS_MASK = 32'h007E19AA;
    localparam logic [31:0] MISA_MASK    = 32'h3C000000;
    localparam logic [31:0] MIE_MASK     = 32'h00000888;
    localparam logic [31:0] MTVEC_MASK   = 32'hFFFFFFFC;
    localparam logic [31:0] MEPC_MASK    = 32'hFFFFFFFC;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;   // MPP is two bits wide

    typedef struct packed {
        logic        valid;
        csr_addr_e   addr;
        logic [31:0] data;     // Already masked
    } csr_wr_t;

    typedef struct packed {
        logic        mret;
        logic        exception;
        exc_code_e   exc_code;
        logic        interrupt_ack;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic        jump;
        logic [31:0] jump_target;
    } trap_req_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] misa;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
    } machine_view_t;

endpackage

// File: csr_access.sv
// CSR address decode, masked write/set/clear data, write gating and read mux
module csr_access
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          read_enable_i,
    input  logic          write_enable_i,
    input  logic          killed_i,
    input  csr_op_e       op_i,
    input  logic [11:0]   addr_i,
    input  logic [31:0]   wdata_i,
    input  trap_req_t     trap_i,
    input  machine_view_t view_i,
    input  logic [31:0]   mip_i,
    input  logic [63:0]   mcycle_i,
    input  logic [63:0]   minstret_i,
    output csr_wr_t       wr_o,
    output logic [31:0]   rdata_o
);

    csr_addr_e   csr_addr;
    logic [31:0] current_val;
    logic [31:0] wmask;
    logic [31:0] wr_data;
    logic        trap_event;
    logic        ro_alias;

    assign csr_addr   = csr_addr_e'(addr_i);
    assign trap_event = trap_i.mret || trap_i.exception || trap_i.interrupt_ack;
    assign ro_alias   = csr_addr inside {CYCLE, CYCLEH, INSTRET, INSTRETH};

    // Current value and writable bits of the addressed register
    always_comb begin
        case (csr_addr)
            MSTATUS:   begin current_val = view_i.mstatus;   wmask = MSTATUS_MASK; end
            MISA:      begin current_val = view_i.misa;      wmask = MISA_MASK;    end
            MIE:       begin current_val = view_i.mie;       wmask = MIE_MASK;     end
            MTVEC:     begin current_val = view_i.mtvec;     wmask = MTVEC_MASK;   end
            MSCRATCH:  begin current_val = view_i.mscratch;  wmask = '1;           end
            MEPC:      begin current_val = view_i.mepc;      wmask = MEPC_MASK;    end
            MCAUSE:    begin current_val = view_i.mcause;    wmask = '1;           end
            MTVAL:     begin current_val = view_i.mtval;     wmask = '1;           end
            MCYCLE:    begin current_val = mcycle_i[31:0];   wmask = '1;           end
            MCYCLEH:   begin current_val = mcycle_i[63:32];  wmask = '1;           end
            MINSTRET:  begin current_val = minstret_i[31:0]; wmask = '1;           end
            MINSTRETH: begin current_val = minstret_i[63:32]; wmask = '1;          end
            default:   begin current_val = '0;               wmask = '0;           end
        endcase
    end

    always_comb begin
        case (op_i)
            CSR_SET:   wr_data = (current_val | wdata_i) & wmask;
            CSR_CLEAR: wr_data = (current_val & ~wdata_i) & wmask;
            default:   wr_data = wdata_i & wmask;   // Plain write
        endcase
    end

    // Trap events take the cycle, the CSR write is dropped
    assign wr_o.valid = write_enable_i && !killed_i && !trap_event;
    assign wr_o.addr  = csr_addr;
    assign wr_o.data  = wr_data;

    always_comb begin
        rdata_o = '0;
        if (read_enable_i && !killed_i) begin
            case (csr_addr)
                MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR: rdata_o = '0;
                MSTATUS:             rdata_o = view_i.mstatus;
                MISA:                rdata_o = view_i.misa;
                MIE:                 rdata_o = view_i.mie;
                MTVEC:               rdata_o = view_i.mtvec;
                MSCRATCH:            rdata_o = view_i.mscratch;
                MEPC:                rdata_o = view_i.mepc;
                MCAUSE:              rdata_o = view_i.mcause;
                MTVAL:               rdata_o = view_i.mtval;
                MIP:                 rdata_o = mip_i;
                MCYCLE, CYCLE:       rdata_o = mcycle_i[31:0];
                MCYCLEH, CYCLEH:     rdata_o = mcycle_i[63:32];
                MINSTRET, INSTRET:   rdata_o = minstret_i[31:0];
                MINSTRETH, INSTRETH: rdata_o = minstret_i[63:32];
                default:             rdata_o = '0;
            endcase
        end
    end

    // Core must trap a write to a user counter alias before it gets here
    a_no_alias_write: assert property (@(posedge clk) disable iff (reset)
        !(read_enable_i && write_enable_i && !killed_i && ro_alias));

endmodule

// File: csr_counters.sv
// mcycle and minstret 64-bit counters with 32-bit half writes
module csr_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        killed_i,
    input  csr_wr_t     wr_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic        mcycle_wr_lo;
    logic        mcycle_wr_hi;
    logic        minstret_wr_lo;
    logic        minstret_wr_hi;

    // A software write to either half holds the count for that cycle
    function automatic logic [63:0] next_count(
        input logic [63:0] count,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] result;
        result = count;
        if (wr_lo)
            result[31:0] = data;
        else if (wr_hi)
            result[63:32] = data;
        else if (inc)
            result = count + 64'd1;
        return result;
    endfunction

    assign mcycle_wr_lo   = wr_i.valid && (wr_i.addr == MCYCLE);
    assign mcycle_wr_hi   = wr_i.valid && (wr_i.addr == MCYCLEH);
    assign minstret_wr_lo = wr_i.valid && (wr_i.addr == MINSTRET);
    assign minstret_wr_hi = wr_i.valid && (wr_i.addr == MINSTRETH);

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= next_count(mcycle, 1'b1, mcycle_wr_lo, mcycle_wr_hi, wr_i.data);
            minstret <= next_count(minstret, !killed_i, minstret_wr_lo, minstret_wr_hi,
                                   wr_i.data);   // Retire only unkilled instructions
        end
    end

    assign mcycle_o   = mcycle;
    assign minstret_o = minstret;

endmodule

// File: csr_machine_regs.sv
// Machine trap and status registers, privilege level, trap entry and mret
module csr_machine_regs
    import csr_pkg::*;
#(
    parameter logic [31:0] MISA_RESET = 32'h40000100
) (
    input  logic          clk,
    input  logic          reset,
    input  trap_req_t     trap_i,
    input  csr_wr_t       wr_i,
    input  irq_code_e     irq_code_i,
    output machine_view_t view_o,
    output priv_e         privilege_o
);

    logic [31:0] mstatus;
    logic [31:0] misa;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    priv_e       privilege;
    logic        trap_enter;
    logic        pc_is_return;   // Exception returns to the faulting pc itself

    assign trap_enter   = trap_i.exception || trap_i.interrupt_ack;
    assign pc_is_return = (trap_i.exc_code == ECALL_FROM_MMODE) ||
                          (trap_i.exc_code == BREAKPOINT);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus   <= '0;
            misa      <= MISA_RESET;
            mie       <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            privilege <= PRIV_MACHINE;
        end else if (trap_i.mret) begin
            mstatus[MSTATUS_MIE_BIT] <= mstatus[MSTATUS_MPIE_BIT];
            privilege <= priv_e'(mstatus[MSTATUS_MPP_LSB +: 2]);
        end else if (trap_enter) begin
            // Common part of exception and interrupt entry
            mstatus[MSTATUS_MPP_LSB +: 2] <= privilege;
            mstatus[MSTATUS_MPIE_BIT]     <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]      <= 1'b0;
            privilege                     <= PRIV_MACHINE;

            if (trap_i.exception) begin
                mcause <= {1'b0, 26'b0, trap_i.exc_code};
                mepc   <= pc_is_return ? trap_i.pc : trap_i.pc + 32'd4;
                if (trap_i.exc_code == ILLEGAL_INSTRUCTION)
                    mtval <= trap_i.instruction;   // Offending instruction word
                else
                    mtval <= trap_i.pc;
            end else begin
                mcause <= {1'b1, 26'b0, irq_code_i};
                // Taken branch in flight resumes at its target
                mepc   <= trap_i.jump ? trap_i.jump_target : trap_i.pc;
            end
        end else if (wr_i.valid) begin
            case (wr_i.addr)
                MSTATUS:  mstatus  <= wr_i.data;
                MISA:     misa     <= wr_i.data;
                MIE:      mie      <= wr_i.data;
                MTVEC:    mtvec    <= wr_i.data;
                MSCRATCH: mscratch <= wr_i.data;
                MEPC:     mepc     <= wr_i.data;
                MCAUSE:   mcause   <= wr_i.data;
                MTVAL:    mtval    <= wr_i.data;
                default:  ;   // Counters or read-only
            endcase
        end
    end

    assign view_o.mstatus  = mstatus;
    assign view_o.misa     = misa;
    assign view_o.mie      = mie;
    assign view_o.mtvec    = mtvec;
    assign view_o.mscratch = mscratch;
    assign view_o.mepc     = mepc;
    assign view_o.mcause   = mcause;
    assign view_o.mtval    = mtval;
    assign privilege_o     = privilege;

    // Core raises at most one trap event per cycle
    a_one_trap_event: assert property (@(posedge clk) disable iff (reset)
        $onehot0({trap_i.mret, trap_i.exception, trap_i.interrupt_ack}));

endmodule

// File: csr_irq_ctrl.sv
// Interrupt sampling into mip, pending flag and cause priority
module csr_irq_ctrl
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   irq_i,
    input  logic          interrupt_ack_i,
    input  machine_view_t view_i,
    output logic [31:0]   mip_o,
    output irq_code_e     irq_code_o,
    output logic          interrupt_pending_o
);

    logic [31:0] mip;
    logic [31:0] enabled;
    logic        global_ie;
    logic        take_irq;

    assign global_ie = view_i.mstatus[MSTATUS_MIE_BIT];
    assign enabled   = view_i.mie & mip;
    assign take_irq  = global_ie && (enabled != '0) && !interrupt_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip                 <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip                 <= irq_i;      // One cycle of sampling
            interrupt_pending_o <= take_irq;   // Dropped for the cycle after an ack
        end
    end

    // Cause only read after pending has been raised
    always_ff @(posedge clk) begin
        if (take_irq) begin
            if (enabled[M_EXT_INT])
                irq_code_o <= M_EXT_INT;
            else if (enabled[M_SW_INT])
                irq_code_o <= M_SW_INT;
            else if (enabled[M_TIM_INT])
                irq_code_o <= M_TIM_INT;
        end
    end

    assign mip_o = mip;

    // Pending only rises while mstatus MIE is set
    a_pending_needs_mie: assert property (@(posedge clk) disable iff (reset)
        $rose(interrupt_pending_o) |-> global_ie);

endmodule

// File: csr_bank.sv
// Machine-mode CSR bank top level joining access, counters, registers and interrupts
module csr_bank
    import csr_pkg::*;
#(
    parameter logic [31:0] MISA_RESET = 32'h40000100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        read_enable_i,
    input  logic        write_enable_i,
    input  logic        killed_i,
    input  csr_op_e     op_i,
    input  logic [11:0] addr_i,
    input  logic [31:0] wdata_i,
    input  trap_req_t   trap_i,
    input  logic [31:0] irq_i,
    output logic [31:0] rdata_o,
    output logic        interrupt_pending_o,
    output priv_e       privilege_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    csr_wr_t       csr_wr;
    machine_view_t view;
    irq_code_e     irq_code;
    logic [31:0]   mip;
    logic [63:0]   mcycle;
    logic [63:0]   minstret;

    csr_access csr_access_inst (
        .clk            (clk),
        .reset          (reset),
        .read_enable_i  (read_enable_i),
        .write_enable_i (write_enable_i),
        .killed_i       (killed_i),
        .op_i           (op_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .trap_i         (trap_i),
        .view_i         (view),
        .mip_i          (mip),
        .mcycle_i       (mcycle),
        .minstret_i     (minstret),
        .wr_o           (csr_wr),
        .rdata_o        (rdata_o)
    );

    csr_counters csr_counters_inst (
        .clk        (clk),
        .reset      (reset),
        .killed_i   (killed_i),
        .wr_i       (csr_wr),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_machine_regs #(
        .MISA_RESET (MISA_RESET)
    ) csr_machine_regs_inst (
        .clk         (clk),
        .reset       (reset),
        .trap_i      (trap_i),
        .wr_i        (csr_wr),
        .irq_code_i  (irq_code),
        .view_o      (view),
        .privilege_o (privilege_o)
    );

    csr_irq_ctrl csr_irq_ctrl_inst (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .interrupt_ack_i     (trap_i.interrupt_ack),
        .view_i              (view),
        .mip_o               (mip),
        .irq_code_o          (irq_code),
        .interrupt_pending_o (interrupt_pending_o)
    );

    // Trap vector and return address for the fetch stage
    assign mtvec_o = view.mtvec;
    assign mepc_o  = view.mepc;

endmodule

// File: tb_csr_bank.sv
// Testbench for the CSR bank: stimulus table, register reference model and checks
module tb_csr_bank
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        K_CSR, K_READ, K_EXC, K_MRET, K_IRQ, K_IDLE,
        K_ACK     // Interrupt ack, only issued inside the irq sequence
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] data;       // Exception code on K_EXC rows
        logic [31:0] pc;
        logic [31:0] instr;
        logic        jump;
        logic [31:0] jtarget;
        logic [31:0] irq;
        logic        killed;
        logic        use_model;
        logic [31:0] expected;   // K_IRQ rows: 1 when pending must rise
    } stim_t;

    localparam logic [11:0] NO_CSR  = 12'h7C0;
    localparam logic [31:0] IRQ_SW  = 32'h0000_0008;
    localparam logic [31:0] IRQ_TIM = 32'h0000_0080;
    localparam logic [31:0] IRQ_EXT = 32'h0000_0800;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        read_enable_i = 1'b0;
    logic        write_enable_i = 1'b0;
    logic        killed_i = 1'b0;
    csr_op_e     op_i = CSR_WRITE;
    logic [11:0] addr_i = '0;
    logic [31:0] wdata_i = '0;
    trap_req_t   trap_i = '0;
    logic [31:0] irq_i = '0;
    logic [31:0] rdata_o;
    logic        interrupt_pending_o;
    priv_e       privilege_o;
    logic [31:0] mtvec_o;
    logic [31:0] mepc_o;

    stim_t       table_q[$];
    int          errors = 0;
    int          row = 0;
    logic [31:0] lcg_state = 32'h3049bfde;

    // Reference model of the bank
    logic [31:0] m_mstatus = '0;
    logic [31:0] m_misa = 32'h4000_0100;
    logic [31:0] m_mie = '0;
    logic [31:0] m_mtvec = '0;
    logic [31:0] m_mscratch = '0;
    logic [31:0] m_mepc = '0;
    logic [31:0] m_mcause = '0;
    logic [31:0] m_mtval = '0;
    logic [31:0] m_mip = '0;
    logic [1:0]  m_priv = 2'b11;
    logic [63:0] m_mcycle = 64'd1;     // Edge that ends reset counts once
    logic [63:0] m_minstret = 64'd1;

    csr_bank csr_bank_inst (
        .clk                 (clk),
        .reset               (reset),
        .read_enable_i       (read_enable_i),
        .write_enable_i      (write_enable_i),
        .killed_i            (killed_i),
        .op_i                (op_i),
        .addr_i              (addr_i),
        .wdata_i             (wdata_i),
        .trap_i              (trap_i),
        .irq_i               (irq_i),
        .rdata_o             (rdata_o),
        .interrupt_pending_o (interrupt_pending_o),
        .privilege_o         (privilege_o),
        .mtvec_o             (mtvec_o),
        .mepc_o              (mepc_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] model_mask(input logic [11:0] addr);
        case (addr)
            MSTATUS:                                   return 32'h007E_19AA;
            MISA:                                      return 32'h3C00_0000;
            MIE:                                       return 32'h0000_0888;
            MTVEC, MEPC:                               return 32'hFFFF_FFFC;
            MSCRATCH, MCAUSE, MTVAL:                   return 32'hFFFF_FFFF;
            MCYCLE, MCYCLEH, MINSTRET, MINSTRETH:      return 32'hFFFF_FFFF;
            default:                                   return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            MSTATUS:             return m_mstatus;
            MISA:                return m_misa;
            MIE:                 return m_mie;
            MTVEC:               return m_mtvec;
            MSCRATCH:            return m_mscratch;
            MEPC:                return m_mepc;
            MCAUSE:              return m_mcause;
            MTVAL:               return m_mtval;
            MIP:                 return m_mip;
            MCYCLE, CYCLE:       return m_mcycle[31:0];
            MCYCLEH, CYCLEH:     return m_mcycle[63:32];
            MINSTRET, INSTRET:   return m_minstret[31:0];
            MINSTRETH, INSTRETH: return m_minstret[63:32];
            default:             return 32'h0000_0000;   // Identity and unknown
        endcase
    endfunction

    // External first, then software, then timer
    function automatic logic [4:0] irq_cause();
        logic [31:0] pend;
        pend = m_mie & m_mip;
        if (pend[11])
            return 5'd11;
        else if (pend[3])
            return 5'd3;
        else if (pend[7])
            return 5'd7;
        return 5'd0;
    endfunction

    // Advance the model by the edge that ends the cycle driven by s
    task automatic model_step(input stim_t s);
        logic [31:0] cur;
        logic [31:0] mask;
        logic [31:0] wval;
        logic        wr;
        logic [4:0]  code;
        cur  = model_read(s.addr);
        mask = model_mask(s.addr);
        case (s.op)
            CSR_SET:   wval = (cur | s.data) & mask;
            CSR_CLEAR: wval = (cur & ~s.data) & mask;
            default:   wval = s.data & mask;
        endcase
        wr = (s.kind == K_CSR) && !s.killed;
        if (wr && s.addr == MCYCLE)
            m_mcycle[31:0] = wval;
        else if (wr && s.addr == MCYCLEH)
            m_mcycle[63:32] = wval;
        else
            m_mcycle = m_mcycle + 64'd1;
        if (wr && s.addr == MINSTRET)
            m_minstret[31:0] = wval;
        else if (wr && s.addr == MINSTRETH)
            m_minstret[63:32] = wval;
        else if (!s.killed)
            m_minstret = m_minstret + 64'd1;   // Retired
        if (wr) begin
            case (s.addr)
                MSTATUS:  m_mstatus = wval;
                MISA:     m_misa = wval;
                MIE:      m_mie = wval;
                MTVEC:    m_mtvec = wval;
                MSCRATCH: m_mscratch = wval;
                MEPC:     m_mepc = wval;
                MCAUSE:   m_mcause = wval;
                MTVAL:    m_mtval = wval;
                default:  ;
            endcase
        end
        if (s.kind == K_MRET) begin
            m_mstatus[3] = m_mstatus[7];
            m_priv = m_mstatus[12:11];
        end else if (s.kind == K_EXC || s.kind == K_ACK) begin
            m_mstatus[12:11] = m_priv;
            m_mstatus[7] = m_mstatus[3];
            m_mstatus[3] = 1'b0;
            m_priv = 2'b11;
            if (s.kind == K_EXC) begin
                code = s.data[4:0];
                m_mcause = {27'd0, code};
                m_mepc = (code == 5'd11 || code == 5'd3) ? s.pc : s.pc + 32'd4;
                m_mtval = (code == 5'd2) ? s.instr : s.pc;
            end else begin
                m_mcause = {1'b1, 26'd0, irq_cause()};
                m_mepc = s.jump ? s.jtarget : s.pc;
            end
        end
        m_mip = s.irq;   // Lines seen at this edge
    endtask

    // Drive one cycle, check at the falling edge, then step the model
    task automatic run_cycle(input stim_t s);
        trap_req_t   t;
        logic [31:0] want;
        t = '0;
        t.mret = (s.kind == K_MRET);
        t.exception = (s.kind == K_EXC);
        t.exc_code = exc_code_e'(s.data[4:0]);
        t.interrupt_ack = (s.kind == K_ACK);
        t.pc = s.pc;
        t.instruction = s.instr;
        t.jump = s.jump;
        t.jump_target = s.jtarget;
        @(posedge clk);
        read_enable_i  <= (s.kind == K_CSR || s.kind == K_READ);
        write_enable_i <= (s.kind == K_CSR);
        killed_i       <= s.killed;
        op_i           <= s.op;
        addr_i         <= s.addr;
        wdata_i        <= s.data;
        trap_i         <= t;
        irq_i          <= s.irq;
        @(negedge clk);
        want = s.use_model ? model_read(s.addr) : s.expected;
        if ((s.kind == K_CSR || s.kind == K_READ) && rdata_o !== want) begin
            $display("Fail rdata_o row %0d addr %03h: got %08h expected %08h",
                     row, s.addr, rdata_o, want);
            errors++;
        end
        if (privilege_o !== m_priv) begin
            $display("Fail privilege_o row %0d: got %h expected %h", row, privilege_o, m_priv);
            errors++;
        end
        if (mepc_o !== m_mepc) begin
            $display("Fail mepc_o row %0d: got %08h expected %08h", row, mepc_o, m_mepc);
            errors++;
        end
        if (mtvec_o !== m_mtvec) begin
            $display("Fail mtvec_o row %0d: got %08h expected %08h", row, mtvec_o, m_mtvec);
            errors++;
        end
        model_step(s);
    endtask

    // Hold the irq lines, wait for pending, ack it, then drop the lines
    task automatic run_irq(input stim_t s);
        stim_t w;
        int    n;
        w = s;
        w.kind = K_IDLE;
        for (n = 0; n < 20 && !(s.expected[0] && interrupt_pending_o); n++) begin
            run_cycle(w);
            if (!s.expected[0] && interrupt_pending_o) begin
                $display("Row %0d: interrupt pending rose while mstatus MIE was clear", row);
                errors++;
            end
        end
        if (s.expected[0] && !interrupt_pending_o) begin
            $display("Row %0d: timeout, interrupt pending did not rise in 20 cycles", row);
            errors++;
        end else if (s.expected[0]) begin
            w.kind = K_ACK;
            run_cycle(w);
            w.kind = K_IDLE;
            w.irq = '0;
            run_cycle(w);
            if (interrupt_pending_o) begin
                $display("Row %0d: interrupt pending still high in the cycle after the ack", row);
                errors++;
            end
        end
        w.kind = K_IDLE;
        w.irq = '0;
        run_cycle(w);
    endtask

    task automatic add(input kind_e kind, input csr_op_e op, input logic [11:0] addr,
                       input logic [31:0] data, input logic [31:0] pc,
                       input logic [31:0] instr, input logic jump,
                       input logic [31:0] jtarget, input logic [31:0] irq,
                       input logic killed, input logic use_model,
                       input logic [31:0] expected);
        stim_t s;
        s = '{kind, op, addr, data, pc, instr, jump, jtarget, irq, killed,
              use_model, expected};
        table_q.push_back(s);
    endtask

    task automatic build_table();
        csr_addr_e rw_regs [4];
        rw_regs = '{MSTATUS, MIE, MTVEC, MSCRATCH};
        // Reset value of misa, unknown address
        add(K_READ, CSR_WRITE, MISA, '0, '0, '0, '0, '0, '0, '0, '0, 32'h4000_0100);
        add(K_READ, CSR_WRITE, NO_CSR, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_CSR,  CSR_WRITE, NO_CSR, lcg_next(), '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, NO_CSR, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        foreach (rw_regs[i]) begin
            add(K_CSR,  CSR_WRITE, rw_regs[i], lcg_next(), '0, '0, '0, '0, '0, '0, 1'b1, '0);
            add(K_READ, CSR_WRITE, rw_regs[i], '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
            add(K_CSR,  CSR_SET,   rw_regs[i], lcg_next(), '0, '0, '0, '0, '0, '0, 1'b1, '0);
            add(K_READ, CSR_WRITE, rw_regs[i], '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
            add(K_CSR,  CSR_CLEAR, rw_regs[i], lcg_next(), '0, '0, '0, '0, '0, '0, 1'b1, '0);
            add(K_READ, CSR_WRITE, rw_regs[i], '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        end
        // Killed access reads zero and writes nothing
        add(K_CSR,  CSR_WRITE, MSCRATCH, lcg_next(), '0, '0, '0, '0, '0, 1'b1, '0, '0);
        add(K_READ, CSR_WRITE, MSCRATCH, '0, '0, '0, '0, '0, '0, 1'b1, '0, '0);
        add(K_READ, CSR_WRITE, MSCRATCH, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        // Exceptions and mret
        add(K_CSR,  CSR_SET, MSTATUS, 32'h8, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_EXC,  CSR_WRITE, '0, 32'd11, 32'h1000, 32'h0000_0073, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MEPC, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, MTVAL, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, MSTATUS, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MSTATUS, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_EXC,  CSR_WRITE, '0, 32'd2, 32'h2000, 32'hFFFF_FFFF, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MTVAL, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_EXC,  CSR_WRITE, '0, 32'd4, 32'h3002, 32'h0000_2083, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MTVAL, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        // Return to user mode, then trap back into machine mode
        add(K_CSR,  CSR_CLEAR, MSTATUS, 32'h1800, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_EXC,  CSR_WRITE, '0, 32'd3, 32'h3100, 32'h0010_0073, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MSTATUS, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        // Interrupts, priority and jump target
        add(K_CSR,  CSR_WRITE, MIE, 32'hFFFF_FFFF, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_CSR,  CSR_SET, MSTATUS, 32'h8, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_IRQ,  CSR_WRITE, '0, '0, 32'h4000, '0, '0, '0, IRQ_EXT | IRQ_SW | IRQ_TIM,
            '0, '0, 32'd1);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_IRQ,  CSR_WRITE, '0, '0, 32'h4100, '0, 1'b1, 32'h5000, IRQ_SW | IRQ_TIM,
            '0, '0, 32'd1);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_IRQ,  CSR_WRITE, '0, '0, 32'h4200, '0, '0, '0, IRQ_TIM, '0, '0, 32'd1);
        add(K_READ, CSR_WRITE, MCAUSE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_MRET, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_CSR,  CSR_CLEAR, MSTATUS, 32'h8, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_IRQ,  CSR_WRITE, '0, '0, 32'h4300, '0, '0, '0, IRQ_EXT | IRQ_SW | IRQ_TIM,
            '0, '0, '0);
        // Counters and user aliases
        add(K_READ, CSR_WRITE, MCYCLE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        repeat (4) add(K_IDLE, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        add(K_READ, CSR_WRITE, MCYCLE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        repeat (3) add(K_IDLE, CSR_WRITE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0, '0);
        add(K_READ, CSR_WRITE, MINSTRET, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, INSTRET, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_CSR,  CSR_WRITE, MCYCLEH, lcg_next(), '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, CYCLEH, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, CYCLE, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
        add(K_READ, CSR_WRITE, INSTRETH, '0, '0, '0, '0, '0, '0, '0, 1'b1, '0);
    endtask

    initial begin
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            row = i;
            if (table_q[i].kind == K_IRQ)
                run_irq(table_q[i]);
            else
                run_cycle(table_q[i]);
        end
        $display("Checks finished over %0d rows with %0d errors", table_q.size(), errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: build.f
csr_pkg.sv
csr_access.sv
csr_counters.sv
csr_machine_regs.sv
csr_irq_ctrl.sv
csr_bank.sv
tb_csr_bank.sv

// File: Makefile
# Verilator build and run of the CSR bank testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_csr_bank -f build.f -Mdir obj_dir
	./obj_dir/Vtb_csr_bank > sim.log
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
